// ==== list.f ====
rtl/mamul_state_pkg.sv
rtl/mamul_sel_pkg.sv
rtl/mamul_seq.sv
rtl/mamul_mem_sel.sv
rtl/mamul_mul_ctl.sv
rtl/mamul_top.sv
dv/mamul_clk_gen.sv
dv/mamul_tb.sv

// ==== dv/mamul_tb.sv ====
// self-checking random testbench for mamul_top, compiled from list.f with mamul_tb as top
`timescale 1ns/10ps

module mamul_tb;

        localparam int clk_period = 4;
        localparam int n_ops = 40;
        // len 3 with three-cycle ack delays needs about 500 cycles, so this leaves margin
        localparam int max_cycles_per_op = 1000;

        // each value is the bit index of that flag in the DUT state word
        typedef enum int {
                s_accumshft, s_iloopn, s_mwrite, s_nprime, s_iloopb, s_iloopa,
                s_jloopn, s_jloopm, s_jloopb, s_jloopa, s_idle, s_none
        } st_t;

        logic rclk, reset, mulop, iss_pulse_dly, aequb, start_mulred_anoteqb;
        logic kill_op, stxa_force_abort, mul_ack, mul_shf_ack, halfpnt_set, expop;
        logic iequtwolenplus2, iequtwolenplus1, jequiminus1, jequlen;
        logic rst_iptr, rst_jptr, incr_iptr, incr_jptr, jjptr_wen, jjptr_sel;
        logic areg_rst, mul_done, memwen, memren, a_rd_sel, ax_rd_sel, b_rd_sel;
        logic ba_rd_sel, m_rd_sel, me_rd_sel, n_rd_sel, m_wr_sel, me_wr_sel;
        logic i_ptr_sel, iminus1_ptr_sel, j_ptr_sel, iminusj_ptr_sel, iminuslenminus1_sel;
        logic mul_req_vld, mul_acc, areg_shf, oprnd2_wen, oprnd2_bypass, oprnd1_wen;
        logic [mamul_sel_pkg::oprnd1_sel_w-1:0] oprnd1_sel;

        // reference model state, its delay flops and the three mul_ctl flops
        st_t st, st_prev;
        int res_wait;
        logic ja_dly, ia_dly, jn_exit_dly, mw_dly, aequb_q, done_q, memwen_q, acc_q;
        logic req_q, op2_q, op1_q;

        // pointer unit stand-in and run bookkeeping
        int i_ptr, j_ptr, len, ack_delay, starts, errors, checks;

        mamul_clk_gen mamul_clk_gen_inst (.clk(rclk));

        mamul_top mamul_top_inst (.*);

        task automatic check_value(input string what, input logic [15:0] got,
                                   input logic [15:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("Mismatch at %0t: %s got %h, expected %h",
                                 $time, what, got, exp);
                end
        endtask

        function automatic logic [10:0] state_word(input st_t s);
                if (s == s_none) begin
                        return '0;
                end else begin
                        return 11'b1 << s;
                end
        endfunction

        // ----------------------------------------
        // stimulus, applied on the falling edge
        // ----------------------------------------
        task automatic drive_inputs();
                logic waiting;
                // a fresh ack delay of 0 to 3 cycles for every state entered
                if (st != st_prev) begin
                        ack_delay = $urandom % 4;
                end
                st_prev = st;
                // a new operand length and operand set for each operation
                if (st == s_idle) begin
                        i_ptr = 0;
                        j_ptr = 0;
                        len = 1 + $urandom % 3;
                        expop = $urandom % 2;
                end
                waiting = st inside {s_jloopb, s_jloopn, s_iloopb, s_nprime, s_iloopn};
                mul_ack = waiting && ack_delay == 0;
                mul_shf_ack = st == s_accumshft && ack_delay == 0;
                if (ack_delay > 0) begin
                        ack_delay--;
                end
                mulop = $urandom % 4 != 0;
                aequb = $urandom % 4 == 0;
                iss_pulse_dly = st == s_idle && $urandom % 2 == 1;
                start_mulred_anoteqb = st == s_idle && $urandom % 8 == 0;
                // kill is rare, abort only bites in the cycle before an M write
                kill_op = $urandom % 300 == 0;
                stxa_force_abort = $urandom % 16 == 0;
                // loop compares come from the i and j counters
                halfpnt_set = i_ptr > len;
                iequtwolenplus2 = i_ptr == 2 * len + 2;
                iequtwolenplus1 = i_ptr == 2 * len + 1;
                jequiminus1 = j_ptr == i_ptr - 1;
                jequlen = j_ptr == len;
        endtask

        // ----------------------------------------
        // reference model, checks and state update
        // ----------------------------------------
        task automatic model_cycle();
                logic start, more_j, half, t_idle, t_ja, t_acc_mw, t_jn_ja, t_jn_ia, t_jn_mw;
                logic abort_l, st_rst, incr_i, incr_j, rst_j, rd_aj, rd_ai, rd_a, rd_b, rd_m, rd_n;
                logic [8:0] exp_seq;
                logic [14:0] exp_mem;
                logic [8:0] exp_mul;
                logic [2:0] op1_sel;
                st_t cur;
                st_t nat;
                cur = st;
                half = halfpnt_set;
                // an A equals B operand in the previous cycle blocks an issue start
                start = (iss_pulse_dly && mulop && !aequb_q) || start_mulred_anoteqb;
                more_j = half ? !jequlen : !jequiminus1;
                t_idle = cur == s_accumshft && iequtwolenplus2 && mul_shf_ack;
                t_ja = cur == s_accumshft && !iequtwolenplus2 && !iequtwolenplus1 && mul_shf_ack;
                t_acc_mw = cur == s_accumshft && iequtwolenplus1 && mul_shf_ack;
                t_jn_ja = cur == s_jloopn && mul_ack && more_j;
                t_jn_ia = cur == s_jloopn && mul_ack && jequiminus1 && !half;
                t_jn_mw = cur == s_jloopn && mul_ack && half && jequlen;
                case (cur)
                        s_idle: nat = start ? s_none : s_idle;
                        s_none: begin
                                // gap cycles before a delayed move or a product
                                if (ia_dly) nat = s_iloopa;
                                else if (ja_dly) nat = s_jloopa;
                                else if (mw_dly || res_wait == 1) nat = s_mwrite;
                                else nat = s_none;
                        end
                        s_jloopa: nat = s_jloopb;
                        s_jloopb: nat = mul_ack ? s_jloopm : s_jloopb;
                        s_jloopm: nat = s_jloopn;
                        s_jloopn: nat = !mul_ack ? s_jloopn : t_jn_ja ? s_jloopa :
                                        t_jn_ia ? s_iloopa : s_none;
                        s_iloopa: nat = s_iloopb;
                        s_iloopb: nat = mul_ack ? s_nprime : s_iloopb;
                        s_nprime: nat = mul_ack ? s_none : s_nprime;
                        s_mwrite: nat = half ? s_accumshft : s_iloopn;
                        s_iloopn: nat = mul_ack ? s_accumshft : s_iloopn;
                        default: nat = !mul_shf_ack ? s_accumshft : t_idle ? s_idle : s_none;
                endcase
                abort_l = nat == s_mwrite && stxa_force_abort;
                st_rst = kill_op || abort_l;

                // sequencer outputs
                rd_aj = (cur == s_jloopn && more_j) || ja_dly;
                rd_ai = (cur == s_jloopn && jequiminus1 && !half) || ia_dly;
                incr_j = t_jn_ja;
                incr_i = (cur == s_mwrite && half) || (cur == s_iloopn && mul_ack);
                rst_j = start || jn_exit_dly || (cur == s_accumshft && !acc_q && half &&
                        !iequtwolenplus2 && !iequtwolenplus1);
                exp_seq = {t_idle, rst_j, incr_i, incr_j, cur == s_jloopm, cur == s_jloopn,
                           start, done_q || abort_l, memwen_q};

                // memory selects, the exponent copies replace A, B and M
                rd_a = rd_aj || rd_ai;
                rd_b = cur == s_jloopa || cur == s_iloopa;
                rd_m = cur == s_jloopb;
                rd_n = cur == s_jloopm || cur == s_mwrite;
                exp_mem = {rd_a || rd_b || rd_m || rd_n, rd_a && !expop, rd_a && expop,
                           rd_b && !expop, rd_b && expop, rd_m && !expop, rd_m && expop, rd_n,
                           memwen_q && !expop, memwen_q && expop, rd_ai, memwen_q && !half,
                           rd_aj || rd_m, cur == s_jloopa || cur == s_jloopm, memwen_q && half};

                // multiplier commands
                if (cur == s_nprime) op1_sel = mamul_sel_pkg::oprnd1_sel_nprime;
                else if (op1_q && cur != s_idle) op1_sel = mamul_sel_pkg::oprnd1_sel_mem;
                else op1_sel = mamul_sel_pkg::oprnd1_sel_mul;
                exp_mul = {req_q, req_q && cur != s_nprime, cur == s_accumshft,
                           op2_q || nat == s_mwrite, nat == s_mwrite, op1_sel, op1_q};

                check_value("sequencer outputs", {rst_iptr, rst_jptr, incr_iptr, incr_jptr,
                            jjptr_wen, jjptr_sel, areg_rst, mul_done, memwen}, exp_seq);
                check_value("memory selects", {memren, a_rd_sel, ax_rd_sel, b_rd_sel, ba_rd_sel,
                            m_rd_sel, me_rd_sel, n_rd_sel, m_wr_sel, me_wr_sel, i_ptr_sel,
                            iminus1_ptr_sel, j_ptr_sel, iminusj_ptr_sel, iminuslenminus1_sel},
                            exp_mem);
                check_value("multiplier controls", {mul_req_vld, mul_acc, areg_shf, oprnd2_wen,
                            oprnd2_bypass, oprnd1_sel, oprnd1_wen}, exp_mul);
                check_value("state word", mamul_top_inst.cur_state.raw, state_word(cur));

                if (cur == s_idle && start && !st_rst) begin
                        starts++;
                end
                aequb_q = aequb;
                done_q = t_idle;
                memwen_q = incr_i;
                acc_q = cur == s_accumshft;
                if (st_rst) begin
                        st = s_idle;
                        res_wait = 0;
                        {ja_dly, ia_dly, jn_exit_dly, mw_dly, req_q, op2_q, op1_q} = '0;
                end else begin
                        // the product of an N-prime or last j-loop request lands later
                        if ((cur == s_nprime && mul_ack) || t_jn_mw) begin
                                res_wait = mamul_state_pkg::mul_result_delay;
                        end else if (res_wait > 0) begin
                                res_wait--;
                        end
                        ja_dly = t_ja;
                        ia_dly = cur == s_idle && start;
                        jn_exit_dly = t_jn_ia;
                        mw_dly = t_acc_mw;
                        req_q = nat inside {s_jloopb, s_jloopn, s_iloopb, s_nprime, s_iloopn};
                        op2_q = nat inside {s_jloopa, s_iloopa, s_jloopm};
                        op1_q = cur inside {s_jloopa, s_jloopm, s_iloopa} ||
                                (cur == s_mwrite && !half);
                        st = nat;
                end

                // pointer unit, j restarts at i-len in the second half
                if (rst_j) j_ptr = half ? i_ptr - len : 0;
                if (incr_j) j_ptr++;
                if (incr_i) i_ptr++;
                if (t_idle) i_ptr = 0;
        endtask

        initial begin
                void'($urandom(29));
                {errors, checks, starts, ack_delay, res_wait, i_ptr, j_ptr} = '0;
                len = 1;
                st = s_idle;
                st_prev = s_idle;
                {ja_dly, ia_dly, jn_exit_dly, mw_dly, aequb_q, done_q, memwen_q, acc_q} = '0;
                {req_q, op2_q, op1_q} = '0;
                reset = 1'b1;
                {mulop, iss_pulse_dly, aequb, start_mulred_anoteqb, kill_op} = '0;
                {stxa_force_abort, mul_ack, mul_shf_ack, halfpnt_set, expop} = '0;
                {iequtwolenplus2, iequtwolenplus1, jequiminus1, jequlen} = '0;
                repeat (10) @(posedge rclk);

                while (starts < n_ops || st != s_idle) begin
                        @(negedge rclk);
                        reset = 1'b0;
                        drive_inputs();
                        #1;
                        model_cycle();
                end

                $display("checks %0d, errors %0d, operations %0d", checks, errors, starts);
                if (errors == 0) begin
                        $display("TEST PASS");
                end else begin
                        $display("TEST FAIL");
                end
                $finish;
        end

        // the run ends here if the operations stop making progress
        initial begin
                #(n_ops * max_cycles_per_op * clk_period);
                $display("watchdog expired after %0d of %0d operations started", starts, n_ops);
                $display("TEST FAIL");
                $finish;
        end

endmodule

// ==== dv/mamul_clk_gen.sv ====
// free-running clock source for the mamul testbench, instantiated once in mamul_tb
`timescale 1ns/10ps

module mamul_clk_gen (
        output logic clk
);

        // 4 ns period with rising edges at 2, 6, 10 ns and so on
        localparam realtime half_period = 2.0;

        initial begin
                clk = 1'b0;
                forever begin
                        #half_period clk = ~clk;
                end
        end

endmodule

// ==== rtl/mamul_top.sv ====
// top level of the modular-multiply control sequencer, the unit seen by the math core
`timescale 1ns/10ps

module mamul_top (
        input  logic rclk,
        input  logic reset,
        input  logic mulop,
        input  logic iss_pulse_dly,
        input  logic aequb,
        input  logic start_mulred_anoteqb,
        input  logic kill_op,
        input  logic stxa_force_abort,
        input  logic mul_ack,
        input  logic mul_shf_ack,
        input  logic halfpnt_set,
        input  logic iequtwolenplus2,
        input  logic iequtwolenplus1,
        input  logic jequiminus1,
        input  logic jequlen,
        input  logic expop,
        output logic rst_iptr,
        output logic rst_jptr,
        output logic incr_iptr,
        output logic incr_jptr,
        output logic jjptr_wen,
        output logic jjptr_sel,
        output logic areg_rst,
        output logic mul_done,
        output logic memwen,
        output logic memren,
        output logic a_rd_sel,
        output logic ax_rd_sel,
        output logic b_rd_sel,
        output logic ba_rd_sel,
        output logic m_rd_sel,
        output logic me_rd_sel,
        output logic n_rd_sel,
        output logic m_wr_sel,
        output logic me_wr_sel,
        output logic i_ptr_sel,
        output logic iminus1_ptr_sel,
        output logic j_ptr_sel,
        output logic iminusj_ptr_sel,
        output logic iminuslenminus1_sel,
        output logic mul_req_vld,
        output logic mul_acc,
        output logic areg_shf,
        output logic oprnd2_wen,
        output logic oprnd2_bypass,
        output logic [mamul_sel_pkg::oprnd1_sel_w-1:0] oprnd1_sel,
        output logic oprnd1_wen
);

        // state and read pulses fan out from the sequencer to both decoders
        mamul_state_pkg::mamul_state_u cur_state;
        mamul_state_pkg::mamul_state_u nxt_state;
        logic rd_aj;
        logic rd_ai;

        // every port name matches its net, so the connections are implicit
        mamul_seq mamul_seq_inst (.*);

        mamul_mem_sel mamul_mem_sel_inst (.*);

        mamul_mul_ctl mamul_mul_ctl_inst (.*);

endmodule

// ==== rtl/mamul_mul_ctl.sv ====
// multiplier command and operand-register decoder, driven by the sequencer in mamul_top
`timescale 1ns/10ps

module mamul_mul_ctl (
        input  logic rclk,
        input  logic reset,
        input  mamul_state_pkg::mamul_state_u cur_state,
        input  mamul_state_pkg::mamul_state_u nxt_state,
        input  logic kill_op,
        input  logic stxa_force_abort,
        input  logic halfpnt_set,
        output logic mul_req_vld,
        output logic mul_acc,
        output logic areg_shf,
        output logic oprnd2_wen,
        output logic oprnd2_bypass,
        output logic [mamul_sel_pkg::oprnd1_sel_w-1:0] oprnd1_sel,
        output logic oprnd1_wen
);

        logic local_abort;
        logic state_reset;
        logic req_pre;
        logic oprnd2_sel;
        logic oprnd2_sel_q;
        logic wrbyp;
        logic memrd4op1;
        logic memrd4op1_q;

        // same abort as the sequencer, so the request drops with the states
        assign local_abort = nxt_state.flags.mwrite & stxa_force_abort;
        assign state_reset = reset | kill_op | local_abort;

        // ----------------------------------------
        // multiplier commands
        // ----------------------------------------

        // request while any waiting-for-ack state is next, held until the ack
        assign req_pre = nxt_state.flags.jloopb | nxt_state.flags.jloopn |
                         nxt_state.flags.iloopb | nxt_state.flags.nprime |
                         nxt_state.flags.iloopn;

        // the N-prime product starts a fresh value, all others accumulate
        assign mul_acc = mul_req_vld & ~cur_state.flags.nprime;
        assign areg_shf = cur_state.flags.accumshft;

        // ----------------------------------------
        // operand registers
        // ----------------------------------------

        // operand 2 captures the A or M word read on the way into these states
        assign oprnd2_sel = nxt_state.flags.jloopa | nxt_state.flags.iloopa |
                            nxt_state.flags.jloopm;

        // the product goes straight through operand 2 on its way to memory
        assign wrbyp = nxt_state.flags.mwrite;
        assign oprnd2_wen = oprnd2_sel_q | wrbyp;
        assign oprnd2_bypass = wrbyp;

        // N[0] feeds operand 1 only in the first half, where iloopn follows
        assign memrd4op1 = cur_state.flags.jloopa | cur_state.flags.jloopm |
                           cur_state.flags.iloopa | (cur_state.flags.mwrite & ~halfpnt_set);

        always_ff @(posedge rclk) begin
                if (state_reset) begin
                        mul_req_vld <= 1'b0;
                        oprnd2_sel_q <= 1'b0;
                        memrd4op1_q <= 1'b0;
                end else begin
                        mul_req_vld <= req_pre;
                        oprnd2_sel_q <= oprnd2_sel;
                        memrd4op1_q <= memrd4op1;
                end
        end

        assign oprnd1_wen = memrd4op1_q;

        // idle falls to the default and parks the mux on the multiplier result
        always_comb begin
                if (cur_state.flags.nprime) begin
                        oprnd1_sel = mamul_sel_pkg::oprnd1_sel_nprime;
                end else if (memrd4op1_q && !cur_state.flags.idle) begin
                        oprnd1_sel = mamul_sel_pkg::oprnd1_sel_mem;
                end else begin
                        oprnd1_sel = mamul_sel_pkg::oprnd1_sel_mul;
                end
        end

        // idle never schedules a request, only the delayed move to iloopa does
        a_no_req_in_idle : assert property (@(posedge rclk) disable iff (reset)
                cur_state.flags.idle |-> !$rose(mul_req_vld));

endmodule

// ==== rtl/mamul_mem_sel.sv ====
// memory read, write and pointer select decoder, driven by the sequencer state in mamul_top
`timescale 1ns/10ps

module mamul_mem_sel (
        input  mamul_state_pkg::mamul_state_u cur_state,
        input  logic rd_aj,
        input  logic rd_ai,
        input  logic memwen,
        input  logic halfpnt_set,
        input  logic expop,
        output logic memren,
        output logic a_rd_sel,
        output logic ax_rd_sel,
        output logic b_rd_sel,
        output logic ba_rd_sel,
        output logic m_rd_sel,
        output logic me_rd_sel,
        output logic n_rd_sel,
        output logic m_wr_sel,
        output logic me_wr_sel,
        output logic i_ptr_sel,
        output logic iminus1_ptr_sel,
        output logic j_ptr_sel,
        output logic iminusj_ptr_sel,
        output logic iminuslenminus1_sel
);

        logic rd_biminusj;
        logic rd_mj;
        logic rd_niminusj;
        logic rd_b0;
        logic rd_n0;
        logic wr_mi;
        logic wr_miminuslenminus1;

        // ----------------------------------------
        // reads that follow the current state
        // ----------------------------------------
        assign rd_biminusj = cur_state.flags.jloopa;
        assign rd_mj = cur_state.flags.jloopb;
        assign rd_niminusj = cur_state.flags.jloopm;
        assign rd_b0 = cur_state.flags.iloopa;
        assign rd_n0 = cur_state.flags.mwrite;

        // the low half of the product lands in M[i] and the high half in M[i-len-1]
        assign wr_mi = memwen & ~halfpnt_set;
        assign wr_miminuslenminus1 = memwen & halfpnt_set;

        assign memren = rd_aj | rd_biminusj | rd_mj | rd_niminusj | rd_ai | rd_b0 | rd_n0;

        // ----------------------------------------
        // operand selects
        // ----------------------------------------

        // an exponentiation uses its own copies of A, B and M
        assign a_rd_sel = (rd_aj | rd_ai) & ~expop;
        assign ax_rd_sel = (rd_aj | rd_ai) & expop;
        assign b_rd_sel = (rd_biminusj | rd_b0) & ~expop;
        assign ba_rd_sel = (rd_biminusj | rd_b0) & expop;
        assign m_rd_sel = rd_mj & ~expop;
        assign me_rd_sel = rd_mj & expop;

        // N is shared, there is no exponent copy
        assign n_rd_sel = rd_niminusj | rd_n0;

        assign m_wr_sel = memwen & ~expop;
        assign me_wr_sel = memwen & expop;

        // ----------------------------------------
        // pointer selects
        // ----------------------------------------
        assign i_ptr_sel = rd_ai;

        // i has already been stepped when the write lands, hence i-1
        assign iminus1_ptr_sel = wr_mi;
        assign j_ptr_sel = rd_aj | rd_mj;
        assign iminusj_ptr_sel = rd_biminusj | rd_niminusj;
        assign iminuslenminus1_sel = wr_miminuslenminus1;

        // the M write lands in accumshft, where the sequencer decodes no read,
        // and the falling memwen samples the write cycle that just ended
        a_no_read_in_write : assert property (@(negedge memwen)
                (memwen === 1'b1) |-> !memren);

endmodule

// ==== rtl/mamul_seq.sv ====
// modular-multiply sequencer FSM, instantiated once in mamul_top to drive both decoders
`timescale 1ns/10ps

module mamul_seq (
        input  logic rclk,
        input  logic reset,
        input  logic mulop,
        input  logic iss_pulse_dly,
        input  logic aequb,
        input  logic start_mulred_anoteqb,
        input  logic kill_op,
        input  logic stxa_force_abort,
        input  logic mul_ack,
        input  logic mul_shf_ack,
        input  logic halfpnt_set,
        input  logic iequtwolenplus2,
        input  logic iequtwolenplus1,
        input  logic jequiminus1,
        input  logic jequlen,
        output mamul_state_pkg::mamul_state_u cur_state,
        output mamul_state_pkg::mamul_state_u nxt_state,
        output logic rd_aj,
        output logic rd_ai,
        output logic rst_iptr,
        output logic rst_jptr,
        output logic incr_iptr,
        output logic incr_jptr,
        output logic jjptr_wen,
        output logic jjptr_sel,
        output logic areg_rst,
        output logic mul_done,
        output logic memwen
);

        localparam int res_w = mamul_state_pkg::mul_result_delay;

        logic aequb_q;
        logic mulop_start;
        logic local_abort;
        logic state_reset;
        logic more_j;
        logic tr2idle_frm_accumshft;
        logic tr2jloopa_frm_accumshft;
        logic tr2jloopa_frm_jloopn;
        logic tr2iloopa_frm_jloopn;
        logic tr2iloopa_frm_idle;
        logic tr2mwrite_frm_jloopn;
        logic tr2mwrite_frm_accumshft;
        logic tr2accumshft_frm_mwrite;
        logic tr2accumshft_frm_iloopn;
        logic jloopa_dly;
        logic iloopa_dly;
        logic jloopn_exit_dly;
        logic mwrite_dly;
        logic mul_done_q;
        logic accumshft_q;
        logic accumshft_pulse;
        logic mul_result_c0;
        logic [res_w-1:0] res_pipe;
        logic n_idle, n_jloopa, n_jloopb, n_jloopm, n_jloopn, n_iloopa;
        logic n_iloopb, n_nprime, n_mwrite, n_iloopn, n_accumshft;

        // ----------------------------------------
        // start, kill and abort
        // ----------------------------------------

        // an A equals B operand seen last cycle belongs to the squaring engine
        assign mulop_start = (iss_pulse_dly & mulop & ~aequb_q) | start_mulred_anoteqb;

        // a forced store that lands on an M write abandons the operation
        assign local_abort = n_mwrite & stxa_force_abort;
        assign state_reset = reset | kill_op | local_abort;
        assign areg_rst = mulop_start;

        // ----------------------------------------
        // transitions
        // ----------------------------------------

        // the first half runs j up to i-1 and the second half up to len
        assign more_j = halfpnt_set ? ~jequlen : ~jequiminus1;

        assign tr2idle_frm_accumshft = cur_state.flags.accumshft & iequtwolenplus2 & mul_shf_ack;
        assign tr2jloopa_frm_accumshft = cur_state.flags.accumshft & ~iequtwolenplus2 &
                                         ~iequtwolenplus1 & mul_shf_ack;
        assign tr2jloopa_frm_jloopn = cur_state.flags.jloopn & mul_ack & more_j;
        assign tr2iloopa_frm_jloopn = cur_state.flags.jloopn & mul_ack & jequiminus1 &
                                      ~halfpnt_set;
        assign tr2iloopa_frm_idle = cur_state.flags.idle & mulop_start;
        assign tr2mwrite_frm_jloopn = cur_state.flags.jloopn & mul_ack & halfpnt_set & jequlen;
        assign tr2mwrite_frm_accumshft = cur_state.flags.accumshft & mul_shf_ack &
                                         iequtwolenplus1;
        assign tr2accumshft_frm_mwrite = cur_state.flags.mwrite & halfpnt_set;
        assign tr2accumshft_frm_iloopn = cur_state.flags.iloopn & mul_ack;

        // the result pipe starts on the ack of the request whose product gets written
        assign mul_result_c0 = (cur_state.flags.nprime & mul_ack) | tr2mwrite_frm_jloopn;

        assign n_idle = state_reset | tr2idle_frm_accumshft |
                        (cur_state.flags.idle & ~mulop_start);
        assign n_jloopa = tr2jloopa_frm_jloopn | jloopa_dly;
        assign n_jloopb = cur_state.flags.jloopa | (cur_state.flags.jloopb & ~mul_ack);
        assign n_jloopm = cur_state.flags.jloopb & mul_ack;
        assign n_jloopn = cur_state.flags.jloopm | (cur_state.flags.jloopn & ~mul_ack);
        assign n_iloopa = iloopa_dly | tr2iloopa_frm_jloopn;
        assign n_iloopb = cur_state.flags.iloopa | (cur_state.flags.iloopb & ~mul_ack);
        assign n_nprime = (cur_state.flags.iloopb & mul_ack) | (cur_state.flags.nprime & ~mul_ack);
        assign n_mwrite = mwrite_dly | res_pipe[res_w-1];
        assign n_iloopn = (cur_state.flags.mwrite & ~halfpnt_set) |
                          (cur_state.flags.iloopn & ~mul_ack);
        assign n_accumshft = tr2accumshft_frm_mwrite | tr2accumshft_frm_iloopn |
                             (cur_state.flags.accumshft & ~mul_shf_ack);

        assign nxt_state.raw = {n_idle, n_jloopa, n_jloopb, n_jloopm, n_jloopn, n_iloopa,
                                n_iloopb, n_nprime, n_mwrite, n_iloopn, n_accumshft};

        // ----------------------------------------
        // state, result pipe and delayed moves
        // ----------------------------------------
        always_ff @(posedge rclk) begin
                if (state_reset) begin
                        cur_state.raw <= '0;
                        cur_state.flags.idle <= 1'b1;
                        res_pipe <= '0;
                        jloopa_dly <= 1'b0;
                        iloopa_dly <= 1'b0;
                        jloopn_exit_dly <= 1'b0;
                        mwrite_dly <= 1'b0;
                end else begin
                        cur_state <= nxt_state;
                        res_pipe <= {res_pipe[res_w-2:0], mul_result_c0};
                        jloopa_dly <= tr2jloopa_frm_accumshft;
                        iloopa_dly <= tr2iloopa_frm_idle;
                        jloopn_exit_dly <= tr2iloopa_frm_jloopn;
                        // the last i skips the j-loop, so the pointer unit needs
                        // an extra cycle to form i-len-1
                        mwrite_dly <= tr2mwrite_frm_accumshft;
                end
        end

        always_ff @(posedge rclk) begin
                if (reset) begin
                        aequb_q <= 1'b0;
                        mul_done_q <= 1'b0;
                        memwen <= 1'b0;
                        accumshft_q <= 1'b0;
                end else begin
                        aequb_q <= aequb;
                        mul_done_q <= tr2idle_frm_accumshft;
                        memwen <= incr_iptr;
                        accumshft_q <= cur_state.flags.accumshft;
                end
        end

        // ----------------------------------------
        // pointer controls and read pulses
        // ----------------------------------------
        assign accumshft_pulse = cur_state.flags.accumshft & ~accumshft_q;

        // A[j] is read while the next j-loop pass is being entered
        assign rd_aj = (cur_state.flags.jloopn & more_j) | jloopa_dly;
        assign rd_ai = (cur_state.flags.jloopn & jequiminus1 & ~halfpnt_set) | iloopa_dly;

        assign incr_jptr = tr2jloopa_frm_jloopn;
        assign incr_iptr = tr2accumshft_frm_mwrite | tr2accumshft_frm_iloopn;
        assign rst_iptr = tr2idle_frm_accumshft;

        // j restarts at 0 each first-half pass and at i-len in the second half
        assign rst_jptr = mulop_start | jloopn_exit_dly |
                          (accumshft_pulse & halfpnt_set & ~iequtwolenplus2 & ~iequtwolenplus1);

        assign jjptr_wen = cur_state.flags.jloopm;
        assign jjptr_sel = cur_state.flags.jloopn;

        // an abort reports done at once so the issuing unit can retire the op
        assign mul_done = mul_done_q | local_abort;

        // transitions, kill and abort leave at most one state flag set, and the
        // gap cycles before a delayed move or a product have none
        a_state_onehot : assert property (@(posedge rclk) disable iff (reset)
                $onehot0(cur_state.raw));

endmodule

// ==== rtl/mamul_sel_pkg.sv ====
// operand-1 mux select width and its one-hot codes for the multiplier command decoder
package mamul_sel_pkg;

        // one select line per operand-1 source
        localparam int oprnd1_sel_w = 3;

        // result fed back from the multiplier, the default source
        localparam logic [oprnd1_sel_w-1:0] oprnd1_sel_mul = 3'b001;

        // word read from the operand memory
        localparam logic [oprnd1_sel_w-1:0] oprnd1_sel_mem = 3'b010;

        // the N-prime register, only during the nprime request
        localparam logic [oprnd1_sel_w-1:0] oprnd1_sel_nprime = 3'b100;

endpackage

// ==== rtl/mamul_state_pkg.sv ====
// state encoding and result latency shared by the multiply sequencer and its decoders
package mamul_state_pkg;

        // one flop per sequencer state
        localparam int num_states = 11;

        // cycles from the multiplier taking an N-prime or final j-loop request
        // until the M write state is next
        localparam int mul_result_delay = 5;

        // named view of the state word, idle sits in the top bit
        typedef struct packed {
                logic idle;
                logic jloopa;
                logic jloopb;
                logic jloopm;
                logic jloopn;
                logic iloopa;
                logic iloopb;
                logic nprime;
                logic mwrite;
                logic iloopn;
                logic accumshft;
        } mamul_state_flags_t;

        // the decoders read the flags, while the one-hot check reads the raw bits
        typedef union packed {
                mamul_state_flags_t flags;
                logic [num_states-1:0] raw;
        } mamul_state_u;

endpackage
